/* design/elevator_pkg.sv */
package elevator_pkg;

    localparam int num_cars    = 2;
    localparam int num_floors  = 4;
    localparam int queue_depth = 8;
    localparam int move_cycles = 8;  // Clock cycles between adjacent floors

    typedef logic [1:0] floor_t;
    typedef logic [3:0] count_t;     // 0 to queue_depth

    typedef enum logic [1:0] {
        kind_crate,
        kind_parcel,
        kind_cart,
        kind_tool
    } kind_t;

    typedef struct packed {
        kind_t  kind;
        floor_t dest;
    } object_t;

    // Explicit valid bit, so an all-zero object is a real one
    typedef struct packed {
        logic    valid;
        object_t obj;
    } slot_t;

    typedef enum logic [1:0] {
        car_idle,
        car_moving,
        car_unloading
    } car_state_t;

    typedef count_t [3:0] kind_counts_t;  // Indexed by kind_t
    typedef logic [3:0][7:0] tally_t;     // Delivered objects, indexed by kind_t

endpackage

/* design/car_if.sv */
`timescale 1ns/1ns

interface car_if;
    import elevator_pkg::*;

    logic    load;   // One-cycle strobe, no handshake
    object_t item;
    count_t  count;  // Objects held by the car
    floor_t  floor;  // Current car position

    modport dispatch (
        output load,
        output item,
        input  count,
        input  floor
    );

    modport car (
        input  load,
        input  item,
        output count,
        output floor
    );

endinterface

/* design/cargo_queue.sv */
`timescale 1ns/1ns

module cargo_queue (
    input  logic                       clk,
    input  logic                       clear,
    input  logic                       load,
    input  elevator_pkg::object_t      item,
    input  logic                       unload,
    input  elevator_pkg::floor_t       floor,
    output elevator_pkg::object_t      head,
    output elevator_pkg::count_t       count,
    output elevator_pkg::kind_counts_t removed
);
    import elevator_pkg::*;

    typedef logic [$clog2(queue_depth)-1:0] slot_idx_t;

    slot_t  slots      [queue_depth];
    slot_t  slots_next [queue_depth];
    count_t count_next;

    // Removal first, then the append lands in the first free slot
    always_comb begin
        count_t kept;

        kept       = '0;
        removed    = '0;
        slots_next = '{default: '0};

        for (int i = 0; i < queue_depth; i++) begin
            if (slots[i].valid) begin
                if (unload && slots[i].obj.dest == floor) begin
                    // Leaves the car here, tallied per kind
                    removed[slots[i].obj.kind] = removed[slots[i].obj.kind] + 1'b1;
                end else begin
                    slots_next[slot_idx_t'(kept)] = slots[i];  // Survivors keep their order
                    kept = kept + 1'b1;
                end
            end
        end

        if (load && kept < count_t'(queue_depth)) begin
            slots_next[slot_idx_t'(kept)] = '{valid: 1'b1, obj: item};
            kept = kept + 1'b1;
        end

        count_next = kept;
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            slots <= '{default: '0};
            count <= '0;
        end else begin
            slots <= slots_next;
            count <= count_next;
        end
    end

    assign head = slots[0].obj;  // Oldest object steers the car

endmodule

/* design/car_motion.sv */
`timescale 1ns/1ns

module car_motion (
    input  logic                  clk,
    input  logic                  clear,
    input  elevator_pkg::count_t  count,
    input  elevator_pkg::object_t head,
    output elevator_pkg::floor_t  floor,
    output logic                  unload
);
    import elevator_pkg::*;

    typedef logic [$clog2(move_cycles)-1:0] timer_t;

    car_state_t state;
    car_state_t state_next;
    floor_t     floor_next;
    timer_t     timer;
    timer_t     timer_next;
    logic       step_done;

    assign step_done = (timer == timer_t'(move_cycles - 1));

    always_comb begin
        state_next = state;
        floor_next = floor;
        timer_next = '0;

        case (state)
            car_idle: begin
                if (count != '0) begin
                    // Cargo for this floor goes out without moving
                    state_next = (head.dest == floor) ? car_unloading : car_moving;
                end
            end
            car_moving: begin
                if (step_done) begin
                    floor_next = (head.dest > floor) ? floor + 1'b1 : floor - 1'b1;
                    if (floor_next == head.dest) begin
                        state_next = car_unloading;  // Arrived
                    end
                end else begin
                    timer_next = timer + 1'b1;
                end
            end
            car_unloading: state_next = car_idle;  // Exactly one cycle
            default:       state_next = car_idle;
        endcase
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state <= car_idle;
            floor <= '0;
            timer <= '0;
        end else begin
            state <= state_next;
            floor <= floor_next;
            timer <= timer_next;
        end
    end

    assign unload = (state == car_unloading);

endmodule

/* design/elevator_car.sv */
`timescale 1ns/1ns

module elevator_car (
    input  logic                       clk,
    input  logic                       clear,
    car_if.car                         bus,
    output logic                       unload,
    output elevator_pkg::kind_counts_t removed
);
    import elevator_pkg::*;

    object_t head;
    count_t  count;
    floor_t  floor;

    cargo_queue i_queue (
        .clk     (clk),
        .clear   (clear),
        .load    (bus.load),
        .item    (bus.item),
        .unload  (unload),
        .floor   (floor),   // Objects for the car's floor leave on unload
        .head    (head),
        .count   (count),
        .removed (removed)
    );

    car_motion i_motion (
        .clk    (clk),
        .clear  (clear),
        .count  (count),
        .head   (head),
        .floor  (floor),
        .unload (unload)
    );

    assign bus.count = count;
    assign bus.floor = floor;

endmodule

/* design/load_dispatch.sv */
`timescale 1ns/1ns

module load_dispatch (
    input  logic                 load_req,
    input  elevator_pkg::kind_t  load_kind,
    input  elevator_pkg::floor_t load_dest,
    car_if.dispatch              cars [elevator_pkg::num_cars],
    output logic                 load_refused
);
    import elevator_pkg::*;

    typedef logic [$clog2(num_cars)-1:0] car_idx_t;

    count_t   counts [num_cars];
    count_t   min_count;
    car_idx_t pick;

    // Strict less-than keeps the lowest index on a tie
    always_comb begin
        min_count = counts[0];
        pick      = '0;
        for (int c = 1; c < num_cars; c++) begin
            if (counts[c] < min_count) begin
                min_count = counts[c];
                pick      = car_idx_t'(c);
            end
        end
    end

    // Least-loaded car full means every car is full
    assign load_refused = load_req && (min_count == count_t'(queue_depth));

    for (genvar c = 0; c < num_cars; c++) begin : g_car
        assign counts[c]    = cars[c].count;
        assign cars[c].load = load_req && !load_refused && (pick == car_idx_t'(c));
        assign cars[c].item = '{kind: load_kind, dest: load_dest};
    end

endmodule

/* design/delivery_tally.sv */
`timescale 1ns/1ns

module delivery_tally (
    input  logic                                                   clk,
    input  logic                                                   clear,
    input  logic [elevator_pkg::num_cars-1:0]                      unload,
    input  elevator_pkg::kind_counts_t [elevator_pkg::num_cars-1:0] removed,
    output elevator_pkg::tally_t                                   delivered
);
    import elevator_pkg::*;

    tally_t tally_next;

    // Several cars may unload in the same cycle
    always_comb begin
        tally_next = delivered;
        for (int c = 0; c < num_cars; c++) begin
            if (unload[c]) begin
                for (int k = 0; k < 4; k++) begin
                    tally_next[k] = tally_next[k] + 8'(removed[c][k]);  // Wraps at 8 bits
                end
            end
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            delivered <= '0;
        end else begin
            delivered <= tally_next;
        end
    end

endmodule

/* design/elevator_bank.sv */
`timescale 1ns/1ns

module elevator_bank (
    input  logic                                             clk,
    input  logic                                             clear,
    input  logic                                             load_req,
    input  elevator_pkg::kind_t                              load_kind,
    input  elevator_pkg::floor_t                             load_dest,
    output logic                                             load_refused,
    output elevator_pkg::floor_t [elevator_pkg::num_cars-1:0] car_floors,
    output elevator_pkg::tally_t                             delivered
);
    import elevator_pkg::*;

    car_if cars [num_cars] ();

    logic         [num_cars-1:0] unload;
    kind_counts_t [num_cars-1:0] removed;

    load_dispatch i_dispatch (
        .load_req     (load_req),
        .load_kind    (load_kind),
        .load_dest    (load_dest),
        .cars         (cars),
        .load_refused (load_refused)
    );

    for (genvar c = 0; c < num_cars; c++) begin : g_car
        elevator_car i_car (
            .clk     (clk),
            .clear   (clear),
            .bus     (cars[c]),
            .unload  (unload[c]),
            .removed (removed[c])
        );

        assign car_floors[c] = cars[c].floor;
    end

    delivery_tally i_tally (
        .clk       (clk),
        .clear     (clear),
        .unload    (unload),
        .removed   (removed),
        .delivered (delivered)
    );

endmodule

/* bench/elevator_bank_assert.sv */
`timescale 1ns/1ns

module elevator_bank_assert (
    input logic                 clk,
    input logic                 clear,
    input logic                 load,
    input logic                 unload,
    input elevator_pkg::floor_t floor,
    input elevator_pkg::count_t count,
    input elevator_pkg::slot_t  slots [elevator_pkg::queue_depth]
);
    import elevator_pkg::*;

    logic [queue_depth-1:0] at_floor;  // Valid slots bound for the car's floor

    int fail_count = 0;  // Failed assertions so far

    for (genvar i = 0; i < queue_depth; i++) begin : g_slot
        assign at_floor[i] = slots[i].valid && (slots[i].obj.dest == floor);
    end

    count_bound: assert property (@(posedge clk) disable iff (clear)
        count <= count_t'(queue_depth))
        else begin
            $error("Cargo count %0d above queue depth", count);
            fail_count++;
        end

    head_valid: assert property (@(posedge clk) disable iff (clear)
        (count != '0) |-> slots[0].valid)
        else begin
            $error("Head slot empty while count is %0d", count);
            fail_count++;
        end

    // Floor holds steady from the unload cycle into the next one
    floor_cleared: assert property (@(posedge clk) disable iff (clear)
        (unload && !load) |=> (at_floor == '0))
        else begin
            $error("Object for floor %0d still queued after unload", floor);
            fail_count++;
        end

endmodule

bind cargo_queue elevator_bank_assert i_assert (
    .clk    (clk),
    .clear  (clear),
    .load   (load),
    .unload (unload),
    .floor  (floor),
    .count  (count),
    .slots  (slots)
);

/* bench/elevator_bank_tb.sv */
`timescale 1ns/1ns

module elevator_bank_tb;
    import elevator_pkg::*;

    localparam int num_entries = 32;
    localparam int burst_len   = 17;  // One more load than both queues hold

    logic                  clk;
    logic                  clear;
    logic                  load_req;
    kind_t                 load_kind;
    floor_t                load_dest;
    logic                  load_refused;
    floor_t [num_cars-1:0] car_floors;
    tally_t                delivered;

    // The expected car is -1 for a refusal and num_cars for any car
    kind_t  tbl_kind  [num_entries];
    floor_t tbl_dest  [num_entries];
    int     tbl_gap   [num_entries];
    int     tbl_car   [num_entries];
    logic   tbl_burst [num_entries];

    count_t dut_counts   [num_cars];
    int     assert_fails [num_cars];
    int     model_count  [num_cars];
    int     model_kind   [4];
    int     errors;
    int     assert_total;
    int     cycles;
    int     cycle_limit;

    elevator_bank i_dut (
        .clk          (clk),
        .clear        (clear),
        .load_req     (load_req),
        .load_kind    (load_kind),
        .load_dest    (load_dest),
        .load_refused (load_refused),
        .car_floors   (car_floors),
        .delivered    (delivered)
    );

    for (genvar c = 0; c < num_cars; c++) begin : g_probe
        assign dut_counts[c]   = i_dut.g_car[c].i_car.i_queue.count;
        assign assert_fails[c] = i_dut.g_car[c].i_car.i_queue.i_assert.fail_count;
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_value(string name, logic [31:0] got, logic [31:0] expected);
        $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        errors++;
    endtask

    // The burst to the top floor is dispatched by least count then lowest index
    task automatic build_table();
        int fill [num_cars];
        int pick;

        fill        = '{default: 0};
        cycle_limit = 8 + 200 + num_entries * num_floors * move_cycles;
        for (int i = 0; i < num_entries; i++) begin
            tbl_kind[i]  = kind_t'($urandom % 4);
            tbl_dest[i]  = floor_t'($urandom % num_floors);
            tbl_gap[i]   = $urandom % 12;
            tbl_car[i]   = num_cars;
            tbl_burst[i] = (i < burst_len);
            if (i < burst_len) begin
                tbl_dest[i] = floor_t'(num_floors - 1);
                tbl_gap[i]  = (i == burst_len - 1) ? 60 : 0;  // Let both cars drain
                pick = 0;
                for (int c = 1; c < num_cars; c++) begin
                    if (fill[c] < fill[pick]) pick = c;
                end
                tbl_car[i] = (fill[pick] == queue_depth) ? -1 : pick;
                if (fill[pick] < queue_depth) fill[pick]++;
            end
            cycle_limit += tbl_gap[i];
        end
        tbl_dest[burst_len] = floor_t'(num_floors - 1);  // Cars already wait there
    endtask

    task automatic apply_entry(int i);
        logic exp_refused;

        exp_refused = (tbl_car[i] == -1);
        @(posedge clk);
        load_req  <= 1'b1;
        load_kind <= tbl_kind[i];
        load_dest <= tbl_dest[i];
        @(negedge clk);
        if (tbl_burst[i]) begin
            for (int c = 0; c < num_cars; c++) begin
                if (dut_counts[c] !== count_t'(model_count[c]))
                    report_value($sformatf("count[%0d]", c), dut_counts[c], model_count[c]);
            end
        end
        if (load_refused !== exp_refused) report_value("load_refused", load_refused, exp_refused);
        if (!exp_refused) model_kind[tbl_kind[i]]++;
        if (tbl_car[i] >= 0 && tbl_car[i] < num_cars) model_count[tbl_car[i]]++;
        if (tbl_gap[i] != 0) begin
            @(posedge clk);
            load_req <= 1'b0;
            repeat (tbl_gap[i] - 1) @(posedge clk);
        end
    endtask

    function automatic logic queues_empty();
        for (int c = 0; c < num_cars; c++) begin
            if (dut_counts[c] != '0) return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        clear       = 1'b1;
        load_req    = 1'b0;
        load_kind   = kind_crate;
        load_dest   = '0;
        errors      = 0;
        model_count = '{default: 0};
        model_kind  = '{default: 0};
        void'($urandom(32'hadc2));
        build_table();

        repeat (8) @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        for (int c = 0; c < num_cars; c++) begin
            if (car_floors[c] !== '0)
                report_value($sformatf("car_floors[%0d]", c), car_floors[c], 0);
        end
        if (delivered !== '0) report_value("delivered", delivered, 0);
        if (load_refused !== 1'b0) report_value("load_refused", load_refused, 0);

        for (int i = 0; i < num_entries; i++) begin
            apply_entry(i);
        end
        @(posedge clk);
        load_req <= 1'b0;

        @(negedge clk);
        while (!queues_empty()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);  // Tally lags the last unload
        for (int k = 0; k < 4; k++) begin
            if (delivered[k] !== 8'(model_kind[k]))
                report_value($sformatf("delivered[%0d]", k), delivered[k], 8'(model_kind[k]));
        end

        assert_total = 0;
        for (int c = 0; c < num_cars; c++) begin
            assert_total += assert_fails[c];
        end

        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, assert_total);
        if (errors == 0 && assert_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Floors move one step at a time and the first delivery happens at the burst floor
    initial begin
        floor_t prev [num_cars];
        logic   seen;
        logic   at_top;
        int     step;

        seen = 1'b0;
        prev = '{default: '0};
        @(negedge clear);
        forever begin
            @(negedge clk);
            at_top = 1'b0;
            for (int c = 0; c < num_cars; c++) begin
                step = int'(car_floors[c]) - int'(prev[c]);
                if (step > 1 || step < -1) begin
                    $display("CHECK FAILED car_floors[%0d] jumped from %h to %h",
                             c, prev[c], car_floors[c]);
                    errors++;
                end
                if (car_floors[c] == floor_t'(num_floors - 1)) at_top = 1'b1;
                prev[c] = car_floors[c];
            end
            if (!seen && delivered !== '0) begin
                seen = 1'b1;
                if (!at_top) report_value("car_floors", car_floors, num_floors - 1);
            end
        end
    end

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles because the cars never drained", cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* vlog.f */
design/elevator_pkg.sv
design/car_if.sv
design/cargo_queue.sv
design/car_motion.sv
design/elevator_car.sv
design/load_dispatch.sv
design/delivery_tally.sv
design/elevator_bank.sv
bench/elevator_bank_assert.sv
bench/elevator_bank_tb.sv

/* Bender.yml */
package:
  name: elevator_bank

sources:
  - target: design
    files:
      - design/elevator_pkg.sv
      - design/car_if.sv
      - design/cargo_queue.sv
      - design/car_motion.sv
      - design/elevator_car.sv
      - design/load_dispatch.sv
      - design/delivery_tally.sv
      - design/elevator_bank.sv
  - target: bench
    files:
      - bench/elevator_bank_assert.sv
      - bench/elevator_bank_tb.sv
